// File: Makefile
SIM = obj_dir/Vdecode_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f src.f --top-module decode_tb

run: compile
	out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "Finished with no errors"

clean:
	rm -rf obj_dir

// File: dv/decode_assertions.sv
`default_nettype none

module decode_assertions
    import core_pkg::*;
(
    input logic     clk_i,
    input logic     rst_n_i,
    input logic     dec_valid_o,
    input logic     dec_ready_i,
    input decoded_t dec_o
);

    a_reset_idle: assert property (@(posedge clk_i) !rst_n_i |-> !dec_valid_o)
        else $error("dec_valid_o high during reset");

    // Held output under back-pressure
    a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_valid_o && !dec_ready_i |=> dec_valid_o && $stable(dec_o))
        else $error("output changed while stalled");

    a_illegal_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dec_valid_o && dec_o.illegal |->
            !(dec_o.en_alu || dec_o.en_branch || dec_o.en_mem || dec_o.reg_write))
        else $error("illegal record with an enable set");

endmodule

bind decode_top decode_assertions u_decode_assertions (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .dec_valid_o (dec_valid_o),
    .dec_ready_i (dec_ready_i),
    .dec_o       (dec_o)
);

`default_nettype wire

// File: dv/decode_tb.sv
`default_nettype none

module decode_tb
    import core_pkg::*;
;

    logic        clk_i;
    logic        rst_n_i;
    logic        instr_valid_i;
    logic        instr_ready_o;
    fetch_word_t instr_i;
    logic        dec_valid_o;
    logic        dec_ready_i;
    decoded_t    dec_o;

    string       name_q[$];
    fetch_word_t word_q[$];
    decoded_t    exp_q[$];
    int          pending_q[$];
    integer      seed = 4341;
    integer      rnd;
    int          n;
    int          idx;
    int          got;
    int          cycles;
    int          limit;
    int          slot;

    decode_top u_dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_ready_o (instr_ready_o),
        .instr_i       (instr_i),
        .dec_valid_o   (dec_valid_o),
        .dec_ready_i   (dec_ready_i),
        .dec_o         (dec_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // ------------------------------
    // Encoders and expected records
    // ------------------------------
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Units {alu, branch, mem}, flags {mem_read, mem_write, rs1_read, rs2_read, reg_write}
    function automatic decoded_t rec(input logic [31:0] eqv, input logic [2:0] units,
                                     input alu_op_e a, input br_op_e b, input mem_op_e m,
                                     input logic [4:0] flags, input logic [31:0] imm,
                                     input logic c);
        decoded_t r;
        r = '0;
        {r.en_alu, r.en_branch, r.en_mem} = units;
        r.alu_op = a;
        r.br_op  = b;
        r.mem_op = m;
        {r.mem_read, r.mem_write, r.rs1_read, r.rs2_read, r.reg_write} = flags;
        r.rs1        = eqv[19:15];
        r.rs2        = eqv[24:20];
        r.rd         = eqv[11:7];
        r.imm        = imm;
        r.compressed = c;
        return r;
    endfunction

    function automatic decoded_t illegal_rec(input logic c);
        decoded_t r;
        r            = '0;
        r.compressed = c;
        r.illegal    = 1'b1;
        return r;
    endfunction

    task automatic add(input string name, input fetch_word_t word, input decoded_t exp);
        name_q.push_back(name);
        word_q.push_back(word);
        exp_q.push_back(exp);
    endtask

    task automatic add_br(input string name, input logic [2:0] f3, input alu_op_e a,
                          input br_op_e b, input logic [12:0] off);
        logic [31:0] w;
        w = enc_b(off, 5'd3, 5'd4, f3);
        add(name, w, rec(w, 3'b110, a, b, MEM_NONE, 5'b00110,
                         {{19{off[12]}}, off}, 1'b0));
    endtask

    task automatic add_ld(input string name, input logic [2:0] f3, input mem_op_e m);
        logic [31:0] w;
        w = enc_i(12'h810, 5'd2, f3, 5'd14, OPC_LOAD);
        add(name, w, rec(w, 3'b101, ALU_MEM, BR_NONE, m, 5'b10101, 32'hFFFFF810, 1'b0));
    endtask

    task automatic add_st(input string name, input logic [2:0] f3, input mem_op_e m);
        logic [31:0] w;
        w = enc_s(12'h07C, 5'd9, 5'd17, f3);
        add(name, w, rec(w, 3'b101, ALU_MEM, BR_NONE, m, 5'b01110, 32'h0000007C, 1'b0));
    endtask

    task automatic add_opi(input string name, input logic [2:0] f3, input logic [11:0] imm,
                           input alu_op_e a, input logic [31:0] exp_imm);
        logic [31:0] w;
        w = enc_i(imm, 5'd21, f3, 5'd22, OPC_OP_IMM);
        add(name, w, rec(w, 3'b100, a, BR_NONE, MEM_NONE, 5'b00101, exp_imm, 1'b0));
    endtask

    task automatic add_op(input string name, input logic [6:0] f7, input logic [2:0] f3,
                          input alu_op_e a);
        logic [31:0] w;
        w = enc_r(f7, 5'd30, 5'd29, f3, 5'd31, OPC_OP);
        add(name, w, rec(w, 3'b100, a, BR_NONE, MEM_NONE, 5'b00111, 32'h0, 1'b0));
    endtask

    task automatic add_rvc(input string name, input logic [15:0] cw, input logic [31:0] eqv,
                           input logic [2:0] units, input alu_op_e a, input br_op_e b,
                           input mem_op_e m, input logic [4:0] flags, input logic [31:0] imm);
        add(name, {16'h0, cw}, rec(eqv, units, a, b, m, flags, imm, 1'b1));
    endtask

    task automatic build_table();
        logic [31:0] w;
        w = {20'h12345, 5'd5, OPC_LUI};
        add("lui", w, rec(w, 3'b100, ALU_LUI, BR_NONE, MEM_NONE, 5'b00001, 32'h12345000, 1'b0));
        w = {20'hFFFFF, 5'd7, OPC_AUIPC};
        add("auipc", w, rec(w, 3'b100, ALU_AUIPC, BR_NONE, MEM_NONE, 5'b00001,
                            32'hFFFFF000, 1'b0));
        w = enc_j(21'h100804, 5'd1);
        add("jal", w, rec(w, 3'b100, ALU_JAL, BR_NONE, MEM_NONE, 5'b00001, 32'hFFF00804, 1'b0));
        w = enc_i(12'hFFC, 5'd3, 3'b000, 5'd1, OPC_JALR);
        add("jalr", w, rec(w, 3'b100, ALU_JALR, BR_NONE, MEM_NONE, 5'b00101,
                           32'hFFFFFFFC, 1'b0));
        add_br("beq", 3'b000, ALU_BEQ, BR_BEQ, 13'h1FF0);
        add_br("bne", 3'b001, ALU_BNE, BR_BNE, 13'h0010);
        add_br("blt", 3'b100, ALU_BLT, BR_BLT, 13'h0802);
        add_br("bge", 3'b101, ALU_BGE, BR_BGE, 13'h1000);
        add_br("bltu", 3'b110, ALU_BLTU, BR_BLTU, 13'h07FE);
        add_br("bgeu", 3'b111, ALU_BGEU, BR_BGEU, 13'h0004);
        add_ld("lb", 3'b000, MEM_LB);
        add_ld("lh", 3'b001, MEM_LH);
        add_ld("lw", 3'b010, MEM_LW);
        add_ld("lbu", 3'b100, MEM_LBU);
        add_ld("lhu", 3'b101, MEM_LHU);
        add_st("sb", 3'b000, MEM_SB);
        add_st("sh", 3'b001, MEM_SH);
        add_st("sw", 3'b010, MEM_SW);
        add_opi("addi", 3'b000, 12'h7FF, ALU_ADDI, 32'h000007FF);
        add_opi("slti", 3'b010, 12'h800, ALU_SLTI, 32'hFFFFF800);
        add_opi("sltiu", 3'b011, 12'h001, ALU_SLTIU, 32'h00000001);
        add_opi("xori", 3'b100, 12'hFFF, ALU_XORI, 32'hFFFFFFFF);
        add_opi("ori", 3'b110, 12'h0A5, ALU_ORI, 32'h000000A5);
        add_opi("andi", 3'b111, 12'h9F0, ALU_ANDI, 32'hFFFFF9F0);
        add_opi("slli", 3'b001, 12'h01F, ALU_SLLI, 32'h0000001F);
        add_opi("srli", 3'b101, 12'h003, ALU_SRLI, 32'h00000003);
        add_opi("srai", 3'b101, 12'h411, ALU_SRAI, 32'h00000011);
        add_op("add", 7'h00, 3'b000, ALU_ADD);
        add_op("sub", 7'h20, 3'b000, ALU_SUB);
        add_op("sll", 7'h00, 3'b001, ALU_SLL);
        add_op("slt", 7'h00, 3'b010, ALU_SLT);
        add_op("sltu", 7'h00, 3'b011, ALU_SLTU);
        add_op("xor", 7'h00, 3'b100, ALU_XOR);
        add_op("srl", 7'h00, 3'b101, ALU_SRL);
        add_op("sra", 7'h20, 3'b101, ALU_SRA);
        add_op("or", 7'h00, 3'b110, ALU_OR);
        add_op("and", 7'h00, 3'b111, ALU_AND);
        add_op("mul", 7'h01, 3'b000, ALU_MUL);
        add_op("mulh", 7'h01, 3'b001, ALU_MULH);
        add_op("mulhsu", 7'h01, 3'b010, ALU_MULHSU);
        add_op("mulhu", 7'h01, 3'b011, ALU_MULHU);
        add_op("div", 7'h01, 3'b100, ALU_DIV);
        add_op("divu", 7'h01, 3'b101, ALU_DIVU);
        add_op("rem", 7'h01, 3'b110, ALU_REM);
        add_op("remu", 7'h01, 3'b111, ALU_REMU);

        // Compressed subset against hand-expanded equivalents
        add_rvc("c.addi", 16'h12F5, enc_i(12'hFFD, 5'd5, 3'b000, 5'd5, OPC_OP_IMM),
                3'b100, ALU_ADDI, BR_NONE, MEM_NONE, 5'b00101, 32'hFFFFFFFD);
        add_rvc("c.li", 16'h451D, enc_i(12'h007, 5'd0, 3'b000, 5'd10, OPC_OP_IMM),
                3'b100, ALU_ADDI, BR_NONE, MEM_NONE, 5'b00101, 32'h00000007);
        add_rvc("c.lui", 16'h6185, {20'h00001, 5'd3, OPC_LUI},
                3'b100, ALU_LUI, BR_NONE, MEM_NONE, 5'b00001, 32'h00001000);
        add_rvc("c.mv", 16'h831E, enc_r(7'h00, 5'd7, 5'd0, 3'b000, 5'd6, OPC_OP),
                3'b100, ALU_ADD, BR_NONE, MEM_NONE, 5'b00111, 32'h0);
        add_rvc("c.add", 16'h931E, enc_r(7'h00, 5'd7, 5'd6, 3'b000, 5'd6, OPC_OP),
                3'b100, ALU_ADD, BR_NONE, MEM_NONE, 5'b00111, 32'h0);
        add_rvc("c.lw", 16'h4044, enc_i(12'h004, 5'd8, 3'b010, 5'd9, OPC_LOAD),
                3'b101, ALU_MEM, BR_NONE, MEM_LW, 5'b10101, 32'h00000004);
        add_rvc("c.sw", 16'hC588, enc_s(12'h008, 5'd10, 5'd11, 3'b010),
                3'b101, ALU_MEM, BR_NONE, MEM_SW, 5'b01110, 32'h00000008);
        add_rvc("c.j", 16'hA801, enc_j(21'h000010, 5'd0),
                3'b100, ALU_JAL, BR_NONE, MEM_NONE, 5'b00001, 32'h00000010);
        add_rvc("c.beqz", 16'hDCF5, enc_b(13'h1FFC, 5'd9, 5'd0, 3'b000),
                3'b110, ALU_BEQ, BR_BEQ, MEM_NONE, 5'b00110, 32'hFFFFFFFC);
        add_rvc("c.bnez", 16'hE019, enc_b(13'h0006, 5'd8, 5'd0, 3'b001),
                3'b110, ALU_BNE, BR_BNE, MEM_NONE, 5'b00110, 32'h00000006);

        // Illegal words
        add("bad opcode", 32'h0000007F, illegal_rec(1'b0));
        add("bad funct", enc_r(7'h20, 5'd1, 5'd2, 3'b001, 5'd3, OPC_OP), illegal_rec(1'b0));
        add("jalr funct3", enc_i(12'h010, 5'd1, 3'b001, 5'd2, OPC_JALR), illegal_rec(1'b0));
        add("c.addi4spn", 32'h00000000, illegal_rec(1'b1));
    endtask

    // ------------------------------
    // Checks
    // ------------------------------
    task automatic fail_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_decoded(input string name, input decoded_t exp, input decoded_t act);
        if (act !== exp) begin
            $display("Mismatch %s expected %h actual %h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s expected %b actual %b", name, exp, act);
            fail_run();
        end
    endtask

    initial begin
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        dec_ready_i   = 1'b0;
        build_table();
        n     = name_q.size();
        limit = n * 8 + 50;

        repeat (2) @(posedge clk_i);
        #1 rst_n_i = 1'b1;
        check_bit("reset dec_valid_o", 1'b0, dec_valid_o);
        check_bit("reset instr_ready_o", 1'b1, instr_ready_o);

        // Single word through two register stages
        @(posedge clk_i);
        #1;
        instr_valid_i = 1'b1;
        instr_i       = word_q[0];
        dec_ready_i   = 1'b1;
        @(negedge clk_i);
        check_bit("latency accept", 1'b1, instr_ready_o);
        @(posedge clk_i);
        #1 instr_valid_i = 1'b0;
        check_bit("latency edge N", 1'b0, dec_valid_o);
        @(posedge clk_i);
        #1 check_bit("latency edge N+1", 1'b1, dec_valid_o);
        check_decoded(name_q[0], exp_q[0], dec_o);
        @(posedge clk_i);
        #1 check_bit("latency drained", 1'b0, dec_valid_o);

        // Whole table under random back-pressure
        idx    = 0;
        got    = 0;
        cycles = 0;
        while (got < n) begin
            @(posedge clk_i);
            #1;
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: outputs stalled, %0d of %0d results after %0d cycles",
                         got, n, cycles);
                fail_run();
            end
            instr_valid_i = (idx < n);
            if (idx < n) begin
                instr_i = word_q[idx];
            end
            rnd         = $random(seed);
            dec_ready_i = rnd[0];
            @(negedge clk_i);
            // Input blocked only with both stages full and the output stalled
            check_bit("back-pressure instr_ready_o",
                      !(pending_q.size() == 2 && !dec_ready_i), instr_ready_o);
            if (dec_valid_o && dec_ready_i) begin
                if (pending_q.size() == 0) begin
                    $display("Output transfer with no instruction in flight");
                    fail_run();
                end
                slot = pending_q.pop_front();
                check_decoded(name_q[slot], exp_q[slot], dec_o);
                got++;
            end
            if (instr_valid_i && instr_ready_o) begin
                pending_q.push_back(idx);
                idx++;
            end
        end

        @(posedge clk_i);
        #1;
        instr_valid_i = 1'b0;
        dec_ready_i   = 1'b1;
        check_bit("final drain", 1'b0, dec_valid_o);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/core_pkg.sv
`default_nettype none

package core_pkg;

    // ------------------------------
    // Major opcodes
    // ------------------------------
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // ------------------------------
    // Function codes
    // ------------------------------
    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000, F3_BNE  = 3'b001, F3_BLT  = 3'b100,
        F3_BGE  = 3'b101, F3_BLTU = 3'b110, F3_BGEU = 3'b111
    } branch_f3_e;

    typedef enum logic [2:0] {
        F3_LB  = 3'b000, F3_LH  = 3'b001, F3_LW  = 3'b010,
        F3_LBU = 3'b100, F3_LHU = 3'b101
    } load_f3_e;

    typedef enum logic [2:0] {
        F3_SB = 3'b000, F3_SH = 3'b001, F3_SW = 3'b010
    } store_f3_e;

    // Shared by OP and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD = 3'b000, F3_SLL = 3'b001, F3_SLT = 3'b010, F3_SLTU = 3'b011,
        F3_XOR = 3'b100, F3_SR  = 3'b101, F3_OR  = 3'b110, F3_AND  = 3'b111
    } alu_f3_e;

    // M extension, funct7 = F7_MULDIV
    typedef enum logic [2:0] {
        F3_MUL = 3'b000, F3_MULH = 3'b001, F3_MULHSU = 3'b010, F3_MULHU = 3'b011,
        F3_DIV = 3'b100, F3_DIVU = 3'b101, F3_REM    = 3'b110, F3_REMU  = 3'b111
    } muldiv_f3_e;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    // ------------------------------
    // Operation codes to execute
    // ------------------------------
    typedef enum logic [5:0] {
        ALU_NONE,
        ALU_LUI, ALU_AUIPC, ALU_JAL, ALU_JALR,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_MEM,
        ALU_ADDI, ALU_SLTI, ALU_SLTIU, ALU_XORI, ALU_ORI, ALU_ANDI,
        ALU_SLLI, ALU_SRLI, ALU_SRAI,
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_MUL, ALU_MULH, ALU_MULHSU, ALU_MULHU,
        ALU_DIV, ALU_DIVU, ALU_REM, ALU_REMU
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } br_op_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    // ------------------------------
    // Compressed subset
    // ------------------------------
    localparam logic [1:0] RVC_Q0 = 2'b00;
    localparam logic [1:0] RVC_Q1 = 2'b01;
    localparam logic [1:0] RVC_Q2 = 2'b10;

    localparam logic [2:0] C0_F3_LW     = 3'b010;
    localparam logic [2:0] C0_F3_SW     = 3'b110;
    localparam logic [2:0] C1_F3_ADDI   = 3'b000;
    localparam logic [2:0] C1_F3_LI     = 3'b010;
    localparam logic [2:0] C1_F3_LUI    = 3'b011;
    localparam logic [2:0] C1_F3_J      = 3'b101;
    localparam logic [2:0] C1_F3_BEQZ   = 3'b110;
    localparam logic [2:0] C1_F3_BNEZ   = 3'b111;
    localparam logic [2:0] C2_F3_MV_ADD = 3'b100;

    // ------------------------------
    // Pipeline payloads
    // ------------------------------
    // Low 16 bits only when [1:0] != 2'b11
    typedef logic [31:0] fetch_word_t;

    typedef struct packed {
        logic [31:0] instr;
        logic        compressed;
        logic        expand_err;
    } expanded_t;

    typedef struct packed {
        logic        en_alu;
        logic        en_branch;
        logic        en_mem;
        alu_op_e     alu_op;
        br_op_e      br_op;
        mem_op_e     mem_op;
        logic        mem_read;
        logic        mem_write;
        logic        rs1_read;
        logic        rs2_read;
        logic        reg_write;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [31:0] imm;
        logic        compressed;
        logic        illegal;
    } decoded_t;

endpackage

`default_nettype wire

// File: hdl/decode_top.sv
`default_nettype none

module decode_top
    import core_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        instr_valid_i,
    output logic        instr_ready_o,
    input  fetch_word_t instr_i,
    output logic        dec_valid_o,
    input  logic        dec_ready_i,
    output decoded_t    dec_o
);

    expanded_t exp_comb;
    expanded_t exp_q;
    logic      exp_valid;
    logic      exp_ready;
    decoded_t  dec_comb;

    // ------------------------------
    // Stage 1, RVC expansion
    // ------------------------------
    rvc_expander u_rvc_expander (
        .instr_i (instr_i),
        .exp_o   (exp_comb)
    );

    pipe_stage #(
        .payload_t (expanded_t)
    ) u_exp_stage (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (instr_valid_i),
        .ready_o (instr_ready_o),
        .data_i  (exp_comb),
        .valid_o (exp_valid),
        .ready_i (exp_ready),
        .data_o  (exp_q)
    );

    // ------------------------------
    // Stage 2, instruction decode
    // ------------------------------
    instr_decoder u_instr_decoder (
        .exp_i (exp_q),
        .dec_o (dec_comb)
    );

    pipe_stage #(
        .payload_t (decoded_t)
    ) u_dec_stage (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (exp_valid),
        .ready_o (exp_ready),
        .data_i  (dec_comb),
        .valid_o (dec_valid_o),
        .ready_i (dec_ready_i),
        .data_o  (dec_o)
    );

endmodule

`default_nettype wire

// File: hdl/instr_decoder.sv
`default_nettype none

module instr_decoder
    import core_pkg::*;
(
    input  expanded_t exp_i,
    output decoded_t  dec_o
);

    logic [31:0] instr;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] shamt;
    logic        bad;

    // ------------------------------
    // Field extraction
    // ------------------------------
    assign instr  = exp_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_i = {{21{instr[31]}}, instr[30:20]};
    assign imm_s = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign shamt = {27'b0, instr[24:20]};

    // ------------------------------
    // Decode
    // ------------------------------
    always_comb begin
        dec_o            = '0;
        bad              = 1'b0;
        dec_o.rs1        = rs1;
        dec_o.rs2        = rs2;
        dec_o.rd         = rd;
        dec_o.compressed = exp_i.compressed;

        case (opcode)
            OPC_LUI: begin
                dec_o.en_alu    = 1'b1;
                dec_o.alu_op    = ALU_LUI;
                dec_o.reg_write = 1'b1;
                dec_o.imm       = imm_u;
            end
            OPC_AUIPC: begin
                dec_o.en_alu    = 1'b1;
                dec_o.alu_op    = ALU_AUIPC;
                dec_o.reg_write = 1'b1;
                dec_o.imm       = imm_u;
            end
            OPC_JAL: begin
                dec_o.en_alu    = 1'b1;
                dec_o.alu_op    = ALU_JAL;
                dec_o.reg_write = 1'b1;
                dec_o.imm       = imm_j;
            end
            OPC_JALR: begin
                dec_o.en_alu    = 1'b1;
                dec_o.alu_op    = ALU_JALR;
                dec_o.rs1_read  = 1'b1;
                dec_o.reg_write = 1'b1;
                dec_o.imm       = imm_i;
                bad             = (funct3 != 3'b000);
            end

            OPC_BRANCH: begin
                // Compare runs in the ALU, target in the branch unit
                dec_o.en_alu    = 1'b1;
                dec_o.en_branch = 1'b1;
                dec_o.rs1_read  = 1'b1;
                dec_o.rs2_read  = 1'b1;
                dec_o.imm       = imm_b;
                case (funct3)
                    F3_BEQ:  {dec_o.alu_op, dec_o.br_op} = {ALU_BEQ, BR_BEQ};
                    F3_BNE:  {dec_o.alu_op, dec_o.br_op} = {ALU_BNE, BR_BNE};
                    F3_BLT:  {dec_o.alu_op, dec_o.br_op} = {ALU_BLT, BR_BLT};
                    F3_BGE:  {dec_o.alu_op, dec_o.br_op} = {ALU_BGE, BR_BGE};
                    F3_BLTU: {dec_o.alu_op, dec_o.br_op} = {ALU_BLTU, BR_BLTU};
                    F3_BGEU: {dec_o.alu_op, dec_o.br_op} = {ALU_BGEU, BR_BGEU};
                    default: bad = 1'b1;
                endcase
            end

            OPC_LOAD: begin
                dec_o.en_alu    = 1'b1;
                dec_o.en_mem    = 1'b1;
                dec_o.alu_op    = ALU_MEM;
                dec_o.mem_read  = 1'b1;
                dec_o.rs1_read  = 1'b1;
                dec_o.reg_write = 1'b1;
                dec_o.imm       = imm_i;
                case (funct3)
                    F3_LB:   dec_o.mem_op = MEM_LB;
                    F3_LH:   dec_o.mem_op = MEM_LH;
                    F3_LW:   dec_o.mem_op = MEM_LW;
                    F3_LBU:  dec_o.mem_op = MEM_LBU;
                    F3_LHU:  dec_o.mem_op = MEM_LHU;
                    default: bad = 1'b1;
                endcase
            end

            OPC_STORE: begin
                dec_o.en_alu    = 1'b1;
                dec_o.en_mem    = 1'b1;
                dec_o.alu_op    = ALU_MEM;
                dec_o.mem_write = 1'b1;
                dec_o.rs1_read  = 1'b1;
                dec_o.rs2_read  = 1'b1;
                dec_o.imm       = imm_s;
                case (funct3)
                    F3_SB:   dec_o.mem_op = MEM_SB;
                    F3_SH:   dec_o.mem_op = MEM_SH;
                    F3_SW:   dec_o.mem_op = MEM_SW;
                    default: bad = 1'b1;
                endcase
            end

            OPC_OP_IMM: begin
                dec_o.en_alu    = 1'b1;
                dec_o.rs1_read  = 1'b1;
                dec_o.reg_write = 1'b1;
                dec_o.imm       = imm_i;
                case (funct3)
                    F3_ADD:  dec_o.alu_op = ALU_ADDI;
                    F3_SLT:  dec_o.alu_op = ALU_SLTI;
                    F3_SLTU: dec_o.alu_op = ALU_SLTIU;
                    F3_XOR:  dec_o.alu_op = ALU_XORI;
                    F3_OR:   dec_o.alu_op = ALU_ORI;
                    F3_AND:  dec_o.alu_op = ALU_ANDI;
                    F3_SLL: begin
                        dec_o.alu_op = ALU_SLLI;
                        dec_o.imm    = shamt;
                        bad          = (funct7 != F7_BASE);
                    end
                    default: begin
                        // Logical or arithmetic right shift by funct7
                        dec_o.imm = shamt;
                        case (funct7)
                            F7_BASE: dec_o.alu_op = ALU_SRLI;
                            F7_ALT:  dec_o.alu_op = ALU_SRAI;
                            default: bad = 1'b1;
                        endcase
                    end
                endcase
            end

            OPC_OP: begin
                dec_o.en_alu    = 1'b1;
                dec_o.rs1_read  = 1'b1;
                dec_o.rs2_read  = 1'b1;
                dec_o.reg_write = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}:      dec_o.alu_op = ALU_ADD;
                    {F7_ALT, F3_ADD}:       dec_o.alu_op = ALU_SUB;
                    {F7_BASE, F3_SLL}:      dec_o.alu_op = ALU_SLL;
                    {F7_BASE, F3_SLT}:      dec_o.alu_op = ALU_SLT;
                    {F7_BASE, F3_SLTU}:     dec_o.alu_op = ALU_SLTU;
                    {F7_BASE, F3_XOR}:      dec_o.alu_op = ALU_XOR;
                    {F7_BASE, F3_SR}:       dec_o.alu_op = ALU_SRL;
                    {F7_ALT, F3_SR}:        dec_o.alu_op = ALU_SRA;
                    {F7_BASE, F3_OR}:       dec_o.alu_op = ALU_OR;
                    {F7_BASE, F3_AND}:      dec_o.alu_op = ALU_AND;
                    {F7_MULDIV, F3_MUL}:    dec_o.alu_op = ALU_MUL;
                    {F7_MULDIV, F3_MULH}:   dec_o.alu_op = ALU_MULH;
                    {F7_MULDIV, F3_MULHSU}: dec_o.alu_op = ALU_MULHSU;
                    {F7_MULDIV, F3_MULHU}:  dec_o.alu_op = ALU_MULHU;
                    {F7_MULDIV, F3_DIV}:    dec_o.alu_op = ALU_DIV;
                    {F7_MULDIV, F3_DIVU}:   dec_o.alu_op = ALU_DIVU;
                    {F7_MULDIV, F3_REM}:    dec_o.alu_op = ALU_REM;
                    {F7_MULDIV, F3_REMU}:   dec_o.alu_op = ALU_REMU;
                    default:                bad = 1'b1;
                endcase
            end

            default: begin
                bad = 1'b1;
            end
        endcase

        // Illegal word leaves no side effects downstream
        if (bad || exp_i.expand_err) begin
            dec_o            = '0;
            dec_o.compressed = exp_i.compressed;
            dec_o.illegal    = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pipe_stage.sv
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     valid_q;
    payload_t data_q;

    // Accept when empty or when the held entry leaves this cycle
    assign ready_o = !valid_q || ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (ready_o) begin
            valid_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (valid_i && ready_o) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

`default_nettype wire

// File: hdl/rvc_expander.sv
`default_nettype none

module rvc_expander
    import core_pkg::*;
(
    input  fetch_word_t instr_i,
    output expanded_t   exp_o
);

    logic [15:0] cw;
    logic [1:0]  quad;
    logic [2:0]  cf3;
    logic [4:0]  rd_full;
    logic [4:0]  rs2_full;
    logic [4:0]  reg_lo_p;
    logic [4:0]  reg_hi_p;
    logic [11:0] imm6_sx;
    logic [11:0] word_off;
    logic [20:0] j_imm;
    logic [12:0] b_imm;

    // ------------------------------
    // Compressed fields
    // ------------------------------
    assign cw       = instr_i[15:0];
    assign quad     = cw[1:0];
    assign cf3      = cw[15:13];
    assign rd_full  = cw[11:7];
    assign rs2_full = cw[6:2];

    // rd' / rs2' and rs1', mapped onto x8..x15
    assign reg_lo_p = {2'b01, cw[4:2]};
    assign reg_hi_p = {2'b01, cw[9:7]};

    assign imm6_sx  = {{6{cw[12]}}, cw[12], cw[6:2]};

    // C.LW / C.SW word offset, zero extended
    assign word_off = {5'b0, cw[5], cw[12:10], cw[6], 2'b00};

    // C.J offset[11|4|9:8|10|6|7|3:1|5]
    assign j_imm = {{9{cw[12]}}, cw[12], cw[8], cw[10:9], cw[6], cw[7],
                    cw[2], cw[11], cw[5:3], 1'b0};

    // C.BEQZ / C.BNEZ offset[8|4:3] and [7:6|2:1|5]
    assign b_imm = {{4{cw[12]}}, cw[12], cw[6:5], cw[2], cw[11:10], cw[4:3], 1'b0};

    // ------------------------------
    // Expansion
    // ------------------------------
    always_comb begin
        exp_o = '0;
        if (quad == 2'b11) begin
            exp_o.instr = instr_i;
        end else begin
            exp_o.compressed = 1'b1;
            case ({quad, cf3})
                {RVC_Q0, C0_F3_LW}: begin
                    exp_o.instr = {word_off, reg_hi_p, F3_LW, reg_lo_p, OPC_LOAD};
                end
                {RVC_Q0, C0_F3_SW}: begin
                    exp_o.instr = {word_off[11:5], reg_lo_p, reg_hi_p, F3_SW,
                                   word_off[4:0], OPC_STORE};
                end
                {RVC_Q1, C1_F3_ADDI}: begin
                    exp_o.instr = {imm6_sx, rd_full, F3_ADD, rd_full, OPC_OP_IMM};
                end
                {RVC_Q1, C1_F3_LI}: begin
                    exp_o.instr = {imm6_sx, 5'd0, F3_ADD, rd_full, OPC_OP_IMM};
                end
                {RVC_Q1, C1_F3_LUI}: begin
                    // rd = x2 is C.ADDI16SP, zero immediate is reserved
                    if (rd_full == 5'd2 || {cw[12], cw[6:2]} == 6'd0) begin
                        exp_o.expand_err = 1'b1;
                    end else begin
                        exp_o.instr = {{14{cw[12]}}, cw[12], cw[6:2], rd_full, OPC_LUI};
                    end
                end
                {RVC_Q1, C1_F3_J}: begin
                    exp_o.instr = {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12],
                                   5'd0, OPC_JAL};
                end
                {RVC_Q1, C1_F3_BEQZ}: begin
                    exp_o.instr = {b_imm[12], b_imm[10:5], 5'd0, reg_hi_p, F3_BEQ,
                                   b_imm[4:1], b_imm[11], OPC_BRANCH};
                end
                {RVC_Q1, C1_F3_BNEZ}: begin
                    exp_o.instr = {b_imm[12], b_imm[10:5], 5'd0, reg_hi_p, F3_BNE,
                                   b_imm[4:1], b_imm[11], OPC_BRANCH};
                end
                {RVC_Q2, C2_F3_MV_ADD}: begin
                    // rs2 = x0 selects C.JR, C.JALR or C.EBREAK
                    if (rs2_full == 5'd0) begin
                        exp_o.expand_err = 1'b1;
                    end else if (!cw[12]) begin
                        exp_o.instr = {F7_BASE, rs2_full, 5'd0, F3_ADD, rd_full, OPC_OP};
                    end else begin
                        exp_o.instr = {F7_BASE, rs2_full, rd_full, F3_ADD, rd_full, OPC_OP};
                    end
                end
                default: begin
                    exp_o.expand_err = 1'b1;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src.f
hdl/core_pkg.sv
hdl/pipe_stage.sv
hdl/rvc_expander.sv
hdl/instr_decoder.sv
hdl/decode_top.sv
dv/decode_assertions.sv
dv/decode_tb.sv
